/* files.f */
verilog/mdpPkg.sv
verilog/mdtPortIf.sv
verilog/mdtRam.sv
verilog/mdtInitCounter.sv
verilog/mdpControl.sv
verilog/violationQueue.sv
verilog/memDepPredictor.sv
verilog/memDepTop.sv
verif/memDepTb.sv

/* verif/mdpPatterns.txt */
# opcode pc(hex) mask(binary, slot1 on the left, slot0 on the right)
# Only Lookup uses the mask, WaitReady and Reset ignore pc and mask
WaitReady 00000000 00
Lookup 00001000 00
Lookup 0000203c 00
Violate 00001010 00
Lookup 00001010 01
Lookup 00005010 01
Lookup 0000100c 10
Lookup 00001014 00
Violate 000010fc 00
Lookup 000000fc 01
Lookup 000010f8 10
Reset 00000000 00
Violate 00002020 00
Violate 00002024 00
Violate 00002040 00
Violate 00002080 00
WaitReady 00000000 00
Lookup 00002020 11
Lookup 0000203c 10
Lookup 0000207c 10
Lookup 00001010 00
Violate 00002030 00
Lookup 0000202c 10
Reset 00000000 00
WaitReady 00000000 00
Lookup 00002020 00
Lookup 00001010 00
Lookup 000010fc 00

/* verif/memDepTb.sv */
// Memory dependency predictor testbench

`timescale 1ns/10ps

module memDepTb import mdpPkg::*; ();

    localparam int RENAME_WIDTH = 2;
    localparam int QUEUE_DEPTH  = 4;
    localparam int CLEAR_CYCLES = 64;
    localparam int WAIT_LIMIT   = 200;

    typedef logic PredVec [RENAME_WIDTH];
    typedef enum {OpLookup, OpViolate, OpReset, OpWaitReady} PatternOp;

    // Low from time zero, first edge is a rising one
    logic   clk = 1'b0;
    logic   rstN;
    logic   fetchValid;
    Pc      fetchPc;
    logic   violationValid;
    Pc      violationPc;
    logic   predValid;
    PredVec pred;
    logic   ready;
    logic   creditReturn;

    // Reference model state
    logic [63:0] shadowTable;
    Pc           pending [$];
    int          credits;
    bit          creditDue;
    int          creditPulses;
    int          sinceReset;
    bit [31:0]   rngState;

    int predErrors;
    int creditErrors;
    int cycleErrors;
    int otherErrors;

    memDepTop #(.RENAME_WIDTH(RENAME_WIDTH), .QUEUE_DEPTH(QUEUE_DEPTH)) i_memDepTop (
        .clk            (clk),
        .rstN           (rstN),
        .fetchValid     (fetchValid),
        .fetchPc        (fetchPc),
        .violationValid (violationValid),
        .violationPc    (violationPc),
        .predValid      (predValid),
        .pred           (pred),
        .ready          (ready),
        .creditReturn   (creditReturn)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic bit [31:0] xorshift(input bit [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Two offset bits dropped, six index bits kept
    function automatic int pcIndex(input Pc pc);
        return int'(pc[7:2]);
    endfunction

    function automatic bit decodeOp(input string text, output PatternOp op);
        decodeOp = 1'b1;
        op = OpLookup;
        case (text)
            "Lookup":    op = OpLookup;
            "Violate":   op = OpViolate;
            "Reset":     op = OpReset;
            "WaitReady": op = OpWaitReady;
            default:     decodeOp = 1'b0;
        endcase
    endfunction

    task automatic checkPred(input string name, input PredVec expected, input PredVec actual);
        logic [RENAME_WIDTH-1:0] expMask;
        logic [RENAME_WIDTH-1:0] actMask;
        bit                      mismatch;
        mismatch = 1'b0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            expMask[i] = expected[i];
            actMask[i] = actual[i];
            if (actual[i] !== expected[i]) begin
                mismatch = 1'b1;
            end
        end
        if (mismatch) begin
            $display("Error: %s expected %b actual %b", name, expMask, actMask);
            predErrors++;
        end
    endtask

    task automatic checkCredits(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            creditErrors++;
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            cycleErrors++;
        end
    endtask

    // One clock, outputs sampled at the falling edge
    task automatic stepCycle();
        Pc pc;
        @(negedge clk);
        // Credit usable one cycle after its pulse
        if (creditDue) begin
            credits++;
            creditDue = 1'b0;
        end
        sinceReset++;
        if (!rstN) begin
            if (ready || predValid || creditReturn) begin
                $display("Outputs active while reset is asserted");
                otherErrors++;
            end
        end else begin
            if (predValid && !ready) begin
                $display("Prediction issued while the table is clearing");
                otherErrors++;
            end
            if (creditReturn) begin
                creditPulses++;
                if (!ready) begin
                    $display("Credit returned while the table is clearing");
                    otherErrors++;
                end
                if (pending.size() == 0) begin
                    $display("Credit returned with no report outstanding");
                    otherErrors++;
                end else begin
                    // Report drains, its entry becomes dependent
                    pc = pending.pop_front();
                    shadowTable[pcIndex(pc)] = 1'b1;
                    creditDue = 1'b1;
                end
            end
        end
    endtask

    task automatic applyReset();
        rstN           = 1'b0;
        fetchValid     = 1'b0;
        violationValid = 1'b0;
        pending.delete();
        shadowTable = '0;
        credits     = QUEUE_DEPTH;
        creditDue   = 1'b0;
        repeat (4) stepCycle();
        rstN       = 1'b1;
        sinceReset = 0;
    endtask

    task automatic doWaitReady(input string name);
        int waited;
        waited = 0;
        // Random filler lookups, ignored during clearing
        while (!ready && waited < WAIT_LIMIT) begin
            rngState   = xorshift(rngState);
            fetchValid = 1'b1;
            fetchPc    = Pc'(rngState);
            stepCycle();
            waited++;
        end
        fetchValid = 1'b0;
        if (!ready) begin
            $display("Timeout: ready never rose after reset in %s", name);
            otherErrors++;
        end else begin
            checkCycles({name, " clear cycles"}, CLEAR_CYCLES, sinceReset);
        end
    endtask

    task automatic doViolate(input string name, input Pc pc);
        int waited;
        waited = 0;
        // Sender stalls without a credit
        while (credits == 0 && waited < WAIT_LIMIT) begin
            stepCycle();
            waited++;
        end
        if (credits == 0) begin
            $display("Timeout: no credit came back for %s", name);
            otherErrors++;
        end else begin
            violationValid = 1'b1;
            violationPc    = pc;
            credits--;
            pending.push_back(pc);
            stepCycle();
            violationValid = 1'b0;
        end
    endtask

    task automatic doLookup(input string name, input Pc pc, input logic [RENAME_WIDTH-1:0] mask);
        PredVec fromFile;
        PredVec fromModel;
        int     waited;
        int     latency;
        int     outstanding;
        int     pulsesBefore;
        waited       = 0;
        outstanding  = pending.size();
        pulsesBefore = creditPulses;
        // Queue head drains one report per cycle
        repeat (outstanding) stepCycle();
        checkCredits({name, " credits returned"}, outstanding, creditPulses - pulsesBefore);
        // Late reports still reach the table first
        while (pending.size() > 0 && waited < WAIT_LIMIT) begin
            stepCycle();
            waited++;
        end
        if (pending.size() > 0) begin
            $display("Timeout: queued reports never drained before %s", name);
            otherErrors++;
        end
        // Last table write lands before the read
        stepCycle();
        fetchValid = 1'b1;
        fetchPc    = pc;
        stepCycle();
        fetchValid = 1'b0;
        latency    = 1;
        while (!predValid && latency < WAIT_LIMIT) begin
            stepCycle();
            latency++;
        end
        if (!predValid) begin
            $display("Timeout: no prediction came back for %s", name);
            otherErrors++;
        end else begin
            checkCycles({name, " latency"}, 1, latency);
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                fromFile[i]  = mask[i];
                fromModel[i] = shadowTable[pcIndex(pc + Pc'(i * INSN_BYTES))];
            end
            checkPred({name, " file"}, fromFile, pred);
            checkPred({name, " model"}, fromModel, pred);
        end
    endtask

    initial begin
        int                      fd;
        int                      fields;
        int                      lineNo;
        string                   line;
        string                   opName;
        string                   name;
        Pc                       pc;
        logic [RENAME_WIDTH-1:0] mask;
        PatternOp                op;
        predErrors     = 0;
        creditErrors   = 0;
        cycleErrors    = 0;
        otherErrors    = 0;
        creditPulses   = 0;
        rngState       = 32'h6ba2_0f90;
        sinceReset     = 0;
        rstN           = 1'b0;
        fetchValid     = 1'b0;
        fetchPc        = '0;
        violationValid = 1'b0;
        violationPc    = '0;
        applyReset();

        fd = $fopen("verif/mdpPatterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file verif/mdpPatterns.txt");
            otherErrors++;
        end else begin
            lineNo = 0;
            while (!$feof(fd) && lineNo < 1000) begin
                line = "";
                void'($fgets(line, fd));
                lineNo++;
                // Comments and blank lines skipped
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %h %b", opName, pc, mask);
                    name   = $sformatf("line %0d %s", lineNo, opName);
                    if (fields != 3 || !decodeOp(opName, op)) begin
                        $display("Malformed pattern on line %0d", lineNo);
                        otherErrors++;
                    end else begin
                        case (op)
                            OpLookup:    doLookup(name, pc, mask);
                            OpViolate:   doViolate(name, pc);
                            OpReset:     applyReset();
                            OpWaitReady: doWaitReady(name);
                            default:     otherErrors++;
                        endcase
                    end
                end
            end
            $fclose(fd);
        end

        $display("Errors: pred %0d, credit %0d, cycle %0d, other %0d",
                 predErrors, creditErrors, cycleErrors, otherErrors);
        if (predErrors + creditErrors + cycleErrors + otherErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/memDepTop.sv */
// Memory dependency predictor top

`timescale 1ns/10ps

module memDepTop import mdpPkg::*; #(
    parameter int RENAME_WIDTH = 2,
    parameter int QUEUE_DEPTH  = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic fetchValid,
    input  Pc    fetchPc,
    input  logic violationValid,
    input  Pc    violationPc,
    output logic predValid,
    output logic pred [RENAME_WIDTH],
    output logic ready,
    output logic creditReturn
);

    // Sequencing
    logic    clearActive;
    logic    counterEnable;
    MdtIndex clearIndex;
    logic    lastIndex;

    // Queue head
    logic drainValid;
    Pc    drainPc;
    logic drainTaken;

    mdtPortIf #(.RENAME_WIDTH(RENAME_WIDTH)) i_mdtPortIf ();

    mdpControl i_mdpControl (
        .clk           (clk),
        .rstN          (rstN),
        .lastIndex     (lastIndex),
        .counterEnable (counterEnable),
        .clearActive   (clearActive),
        .ready         (ready)
    );

    mdtInitCounter i_mdtInitCounter (
        .clk           (clk),
        .rstN          (rstN),
        .counterEnable (counterEnable),
        .clearIndex    (clearIndex),
        .lastIndex     (lastIndex)
    );

    violationQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_violationQueue (
        .clk            (clk),
        .rstN           (rstN),
        .violationValid (violationValid),
        .violationPc    (violationPc),
        .clearActive    (clearActive),
        .drainTaken     (drainTaken),
        .drainValid     (drainValid),
        .drainPc        (drainPc),
        .creditReturn   (creditReturn)
    );

    memDepPredictor #(.RENAME_WIDTH(RENAME_WIDTH)) i_memDepPredictor (
        .clk         (clk),
        .rstN        (rstN),
        .fetchValid  (fetchValid),
        .fetchPc     (fetchPc),
        .clearActive (clearActive),
        .clearIndex  (clearIndex),
        .drainValid  (drainValid),
        .drainPc     (drainPc),
        .drainTaken  (drainTaken),
        .predValid   (predValid),
        .pred        (pred),
        .mdt         (i_mdtPortIf.predictor)
    );

    mdtRam #(.RENAME_WIDTH(RENAME_WIDTH)) i_mdtRam (
        .clk (clk),
        .mdt (i_mdtPortIf.tableSide)
    );

endmodule

/* verilog/memDepPredictor.sv */
// Lookup and learning datapath

`timescale 1ns/10ps

module memDepPredictor import mdpPkg::*; #(
    parameter int RENAME_WIDTH = 2
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        fetchValid,
    input  Pc           fetchPc,
    input  logic        clearActive,
    input  MdtIndex     clearIndex,
    input  logic        drainValid,
    input  Pc           drainPc,
    output logic        drainTaken,
    output logic        predValid,
    output logic        pred [RENAME_WIDTH],
    mdtPortIf.predictor mdt
);

    // Queue head taken whenever the table is free
    assign drainTaken = drainValid && !clearActive;

    // Read addresses
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (clearActive) begin
                // Kept off the entry being cleared
                mdt.readAddr[i] = clearIndex + MdtIndex'(i + 1);
            end else begin
                // Consecutive instructions of the group
                mdt.readAddr[i] = toMdtIndex(fetchPc + Pc'(i * INSN_BYTES));
            end
        end
    end

    // Write port
    // Clearing owns it, otherwise the drained report sets its entry
    always_comb begin
        if (clearActive) begin
            mdt.writeEnable        = 1'b1;
            mdt.writeAddr          = clearIndex;
            mdt.writeData.dependent = 1'b0;
        end else begin
            mdt.writeEnable        = drainTaken;
            mdt.writeAddr          = toMdtIndex(drainPc);
            mdt.writeData.dependent = 1'b1;
        end
    end

    // Lines up with the registered table read
    always_ff @(posedge clk) begin
        if (!rstN) begin
            predValid <= 1'b0;
        end else begin
            predValid <= fetchValid && !clearActive;
        end
    end

    // Dependent bit means wait for older stores
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            pred[i] = mdt.readData[i].dependent;
        end
    end

endmodule

/* verilog/violationQueue.sv */
// Violation report queue with credit return

`timescale 1ns/10ps

module violationQueue import mdpPkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic violationValid,
    input  Pc    violationPc,
    input  logic clearActive,
    input  logic drainTaken,
    output logic drainValid,
    output Pc    drainPc,
    output logic creditReturn
);

    localparam int PTR_BITS   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

    // Report storage
    Pc buffer [QUEUE_DEPTH];

    logic [PTR_BITS-1:0]   wrPtr;
    logic [PTR_BITS-1:0]   rdPtr;
    logic [COUNT_BITS-1:0] count;
    logic                  enqueue;
    logic                  dequeue;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Sender holds a credit for every report
    assign enqueue = violationValid;
    assign dequeue = drainTaken;

    always_ff @(posedge clk) begin
        if (enqueue) begin
            buffer[wrPtr] <= violationPc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (enqueue) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (dequeue) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({enqueue, dequeue})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head held back while the table is being cleared
    assign drainValid = (count != '0) && !clearActive;
    assign drainPc    = buffer[rdPtr];

    // One credit back per report leaving
    assign creditReturn = dequeue;

    // Full queue plus a new report means the sender overspent its credits
    creditRespected: assert property (
        @(posedge clk) disable iff (!rstN)
        violationValid |-> (count != COUNT_BITS'(QUEUE_DEPTH))
    ) else $error("violationQueue: report sent without credit");

endmodule

/* verilog/mdpControl.sv */
// Predictor sequencing FSM

`timescale 1ns/10ps

module mdpControl (
    input  logic clk,
    input  logic rstN,
    input  logic lastIndex,
    output logic counterEnable,
    output logic clearActive,
    output logic ready
);

    // Clear walks the table, Run serves lookups
    typedef enum logic {
        Clear,
        Run
    } CtrlState;

    CtrlState state;
    CtrlState nextState;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Clear;
        end else begin
            state <= nextState;
        end
    end

    // Run holds until reset
    always_comb begin
        nextState = state;
        case (state)
            Clear: begin
                if (lastIndex) begin
                    nextState = Run;
                end
            end
            Run: begin
                nextState = Run;
            end
            default: begin
                nextState = Clear;
            end
        endcase
    end

    assign clearActive = (state == Clear);
    // Counter parks on the top entry after the walk
    assign counterEnable = (state == Clear) && !lastIndex;
    assign ready = (state == Run);

    // Only reset brings the table back to clearing
    noReturnToClear: assert property (
        @(posedge clk) disable iff (!rstN) (state == Run && rstN) |=> (state == Run)
    ) else $error("mdpControl: left Run without reset");

endmodule

/* verilog/mdtInitCounter.sv */
// Table clearing index counter

`timescale 1ns/10ps

module mdtInitCounter import mdpPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    counterEnable,
    output MdtIndex clearIndex,
    output logic    lastIndex
);

    // Walk from entry zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            clearIndex <= '0;
        end else if (counterEnable) begin
            clearIndex <= clearIndex + MdtIndex'(1);
        end
    end

    // Top entry reached
    assign lastIndex = (clearIndex == MdtIndex'(MDT_ENTRIES - 1));

endmodule

/* verilog/mdtRam.sv */
// Dependency table storage

`timescale 1ns/10ps

module mdtRam import mdpPkg::*; #(
    parameter int RENAME_WIDTH = 2
) (
    input logic         clk,
    mdtPortIf.tableSide mdt
);

    // One sticky bit per entry
    MdtEntry mem [MDT_ENTRIES];

    // Single write port
    always_ff @(posedge clk) begin
        if (mdt.writeEnable) begin
            mem[mdt.writeAddr] <= mdt.writeData;
        end
    end

    // Registered reads
    // Result appears the cycle after the address
    always_ff @(posedge clk) begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            mdt.readData[i] <= mem[mdt.readAddr[i]];
        end
    end

    // Write address comes from the predictor mux
    // An X here would corrupt an unknown entry
    writeAddrKnown: assert property (
        @(posedge clk) mdt.writeEnable |-> !$isunknown(mdt.writeAddr)
    ) else $error("mdtRam: write with unknown address");

endmodule

/* verilog/mdtPortIf.sv */
// Dependency table port bundle

`timescale 1ns/10ps

interface mdtPortIf import mdpPkg::*; #(
    parameter int RENAME_WIDTH = 2
);

    // Read side, one port per rename slot
    MdtIndex readAddr [RENAME_WIDTH];
    MdtEntry readData [RENAME_WIDTH];

    // Single write port
    logic    writeEnable;
    MdtIndex writeAddr;
    MdtEntry writeData;

    // Address and write source
    modport predictor (
        output readAddr,
        output writeEnable,
        output writeAddr,
        output writeData,
        input  readData
    );

    // Storage side
    // Named tableSide since table is a reserved word
    modport tableSide (
        input  readAddr,
        input  writeEnable,
        input  writeAddr,
        input  writeData,
        output readData
    );

endinterface

/* verilog/mdpPkg.sv */
// Memory dependency predictor
// Shared widths and types

package mdpPkg;

    // Program counter width and instruction size
    parameter int PC_BITS    = 32;
    parameter int INSN_BYTES = 4;

    // Byte offset bits below the instruction index
    parameter int INSN_OFFSET_BITS = $clog2(INSN_BYTES);

    // Dependency table geometry
    parameter int MDT_INDEX_BITS = 6;
    parameter int MDT_ENTRIES    = 2 ** MDT_INDEX_BITS;

    // Program counter path
    typedef logic [PC_BITS-1:0] Pc;

    // Table index
    typedef logic [MDT_INDEX_BITS-1:0] MdtIndex;

    // One table entry, a sticky bit
    typedef struct packed {
        logic dependent;
    } MdtEntry;

    // Index from PC
    // Low offset bits dropped, upper bits alias onto the same entry
    function automatic MdtIndex toMdtIndex(input Pc pc);
        return pc[INSN_OFFSET_BITS +: MDT_INDEX_BITS];
    endfunction

endpackage
